// ==== rtl/align_types_pkg.sv ====
`default_nettype none

package align_types_pkg;

	// image geometry
	localparam int pixel_w = 12;
	localparam int tbl_aw  = 8;

	// edge position or difference of two positions
	typedef logic signed [pixel_w-1:0] pixel_t;

	// pixel-to-step table index
	typedef logic [tbl_aw-1:0] tbl_addr_t;

	// largest index, used for any magnitude beyond the table
	localparam tbl_addr_t tbl_addr_max = '1;

	// edges reported by the camera front end
	typedef enum logic [1:0] {
		edge_lo = 2'd0,
		edge_ro = 2'd1,
		edge_li = 2'd2,
		edge_ri = 2'd3
	} edge_id_e;

endpackage

`default_nettype wire

// ==== rtl/motor_pkg.sv ====
`default_nettype none

package motor_pkg;

	// signed step count, also the axis position
	typedef logic signed [31:0] step_t;

	// step period in clock cycles
	typedef logic [15:0] speed_t;

	// stepper drive states
	typedef enum logic {
		drive_idle = 1'b0,
		drive_run  = 1'b1
	} drive_state_e;

endpackage

`default_nettype wire

// ==== rtl/edge_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_sampler
	import align_types_pkg::*;
(
	input  logic     clk,
	input  logic     resetn,
	input  logic     edge_valid,
	input  edge_id_e edge_id,
	input  pixel_t   edge_y,
	input  logic     frame_end,
	output logic     img_pulse,
	output pixel_t   lo_y,
	output pixel_t   ro_y,
	output pixel_t   li_y,
	output pixel_t   ri_y,
	output logic     outer_valid,
	output logic     inner_valid
);

	// positions of the frame in progress
	pixel_t     edge_pos [0:3];
	logic [3:0] seen;

	// a repeated report simply overwrites
	always_ff @(posedge clk) begin
		if (edge_valid)
			edge_pos[edge_id] <= edge_y;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			seen        <= '0;
			img_pulse   <= 1'b0;
			outer_valid <= 1'b0;
			inner_valid <= 1'b0;
		end else begin
			img_pulse <= frame_end;
			if (frame_end) begin
				outer_valid <= seen[edge_lo] & seen[edge_ro];
				inner_valid <= seen[edge_li] & seen[edge_ri];
				seen        <= '0;
			end
			// report in the frame_end cycle counts for the next frame
			if (edge_valid)
				seen[edge_id] <= 1'b1;
		end
	end

	// frame record
	always_ff @(posedge clk) begin
		if (frame_end) begin
			lo_y <= edge_pos[edge_lo];
			ro_y <= edge_pos[edge_ro];
			li_y <= edge_pos[edge_li];
			ri_y <= edge_pos[edge_ri];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/step_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_table
	import align_types_pkg::*, motor_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      tbl_wr,
	input  tbl_addr_t tbl_addr,
	input  tbl_addr_t tbl_rd_addr,
	input  step_t     tbl_data,
	output step_t     tbl_rd_data
);

	localparam int depth = 1 << $bits(tbl_addr_t);

	// step count per pixel of error
	step_t mem [0:depth-1];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < depth; i++)
				mem[i] <= '0;
		end else if (tbl_wr) begin
			mem[tbl_addr] <= tbl_data;
		end
	end

	// registered read, a write in the same cycle shows up one read later
	always_ff @(posedge clk) begin
		if (!resetn)
			tbl_rd_data <= '0;
		else
			tbl_rd_data <= mem[tbl_rd_addr];
	end

endmodule

`default_nettype wire

// ==== rtl/stepper_drive.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepper_drive
	import motor_pkg::*;
(
	input  logic   clk,
	input  logic   resetn,
	input  logic   mv_start,
	input  logic   mv_abs,
	input  speed_t mv_speed,
	input  step_t  mv_step,
	output logic   step_pulse,
	output logic   step_dir,
	output logic   motor_busy,
	output step_t  motor_pos
);

	drive_state_e state;
	step_t        target;
	step_t        next_target;
	speed_t       period;
	speed_t       tick_cnt;

	assign next_target = mv_abs ? mv_step : motor_pos + mv_step;
	assign motor_busy  = (state == drive_run);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state      <= drive_idle;
			motor_pos  <= '0;
			step_pulse <= 1'b0;
			step_dir   <= 1'b0;
			tick_cnt   <= '0;
		end else begin
			step_pulse <= 1'b0;
			case (state)
				drive_idle: begin
					if (mv_start) begin
						state    <= drive_run;
						target   <= next_target;
						step_dir <= (next_target > motor_pos);
						// zero period runs at full rate
						period   <= (mv_speed == '0) ? speed_t'(1) : mv_speed;
						tick_cnt <= '0;
					end
				end
				drive_run: begin
					if (motor_pos == target) begin
						state <= drive_idle;
					end else if (tick_cnt == period - 1'b1) begin
						tick_cnt   <= '0;
						step_pulse <= 1'b1;
						motor_pos  <= step_dir ? motor_pos + 1 : motor_pos - 1;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: state <= drive_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/align_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module align_ctl
	import align_types_pkg::*, motor_pkg::*;
#(
	parameter bit l2r = 1'b1
) (
	input  logic      clk,
	input  logic      resetn,
	input  logic      req_go,
	input  logic      req_ecf,
	input  logic      req_dep_img,
	input  logic      req_abs,
	input  pixel_t    req_img_dst,
	input  pixel_t    req_img_tol,
	input  speed_t    req_speed,
	input  step_t     req_step,
	input  logic      img_pulse,
	input  logic      outer_valid,
	input  logic      inner_valid,
	input  pixel_t    lo_y,
	input  pixel_t    ro_y,
	input  pixel_t    li_y,
	input  pixel_t    ri_y,
	input  logic      motor_busy,
	input  logic      dep_busy,
	output tbl_addr_t tbl_rd_addr,
	input  step_t     tbl_rd_data,
	output logic      mv_start,
	output speed_t    mv_speed,
	output step_t     mv_step,
	output logic      mv_abs,
	output logic      exe_done
);

	// busy history, bit 0 current interval, bit 1 last completed one
	logic [1:0] self_hist;
	logic [1:0] dep_hist;
	logic       self_idle;
	logic       dep_idle;

	// pipeline valids
	logic pen_d1;
	logic pen_d2;
	logic pen_d3;
	logic pen_d4;
	logic pen_d5;
	logic pen_d6;

	// pipeline payload
	pixel_t o_diff_d1;
	pixel_t i_diff_d1;
	logic   i_valid_d1;
	pixel_t oi_gap;
	pixel_t ecf_d2;
	pixel_t pos_d3;
	pixel_t err_d4;
	pixel_t mag;
	logic   needback_d5;
	logic   pos_ok_d5;

	// direct mode completion tracking
	logic dir_wait;
	logic dir_seen;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			self_hist <= '0;
			dep_hist  <= '0;
			self_idle <= 1'b0;
			dep_idle  <= 1'b0;
		end else if (img_pulse) begin
			// img_pulse cycle still belongs to the interval that ends here
			self_idle <= ~(self_hist[1] | self_hist[0] | motor_busy);
			dep_idle  <= ~(dep_hist[1] | dep_hist[0] | dep_busy);
			self_hist <= {self_hist[0] | motor_busy, 1'b0};
			dep_hist  <= {dep_hist[0] | dep_busy, 1'b0};
		end else begin
			if (motor_busy)
				self_hist[0] <= 1'b1;
			if (dep_busy)
				dep_hist[0] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pen_d1 <= 1'b0;
			pen_d2 <= 1'b0;
			pen_d3 <= 1'b0;
			pen_d4 <= 1'b0;
			pen_d5 <= 1'b0;
			pen_d6 <= 1'b0;
		end else begin
			pen_d1 <= img_pulse & req_dep_img & outer_valid;
			pen_d2 <= pen_d1;
			pen_d3 <= pen_d2;
			pen_d4 <= pen_d3;
			pen_d5 <= pen_d4;
			pen_d6 <= pen_d5;
		end
	end

	// edge differences, sign follows the measurement direction
	always_ff @(posedge clk) begin
		if (img_pulse) begin
			i_valid_d1 <= inner_valid;
			if (l2r) begin
				o_diff_d1 <= lo_y - ro_y;
				i_diff_d1 <= li_y - ri_y;
			end else begin
				o_diff_d1 <= ro_y - lo_y;
				i_diff_d1 <= ri_y - li_y;
			end
		end
	end

	// eccentricity term, a quarter of the outer to inner gap
	assign oi_gap = o_diff_d1 - i_diff_d1;

	always_ff @(posedge clk) begin
		if (pen_d1)
			ecf_d2 <= oi_gap >>> 2;
		if (pen_d2)
			pos_d3 <= (req_ecf && i_valid_d1) ? i_diff_d1 - ecf_d2 : o_diff_d1;
		if (pen_d3)
			err_d4 <= (pos_d3 > 0) ? pos_d3 - req_img_dst : pos_d3 + req_img_dst;
	end

	assign mag = (err_d4 > 0) ? err_d4 : -err_d4;

	// tolerance and table lookup address
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tbl_rd_addr <= '0;
		end else if (pen_d4) begin
			if ($unsigned(mag) >= 12'(tbl_addr_max))
				tbl_rd_addr <= tbl_addr_max;
			else
				tbl_rd_addr <= mag[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (pen_d4) begin
			needback_d5 <= (err_d4 <= 0);
			pos_ok_d5   <= (mag < req_img_tol);
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mv_start <= 1'b0;
		end else begin
			mv_start <= 1'b0;
			if (req_dep_img) begin
				if (pen_d6 && self_idle && !pos_ok_d5 && !motor_busy)
					mv_start <= 1'b1;
			end else if (req_go && !motor_busy) begin
				mv_start <= 1'b1;
			end
		end
	end

	// move payload, only sampled with mv_start
	always_ff @(posedge clk) begin
		mv_speed <= req_speed;
		if (req_dep_img) begin
			mv_step <= needback_d5 ? -tbl_rd_data : tbl_rd_data;
			mv_abs  <= 1'b0;
		end else begin
			mv_step <= req_step;
			mv_abs  <= req_abs;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			exe_done <= 1'b0;
			dir_wait <= 1'b0;
			dir_seen <= 1'b0;
		end else if (req_go) begin
			exe_done <= 1'b0;
			dir_wait <= ~req_dep_img;
			dir_seen <= 1'b0;
		end else if (req_dep_img) begin
			if (pen_d6)
				exe_done <= pos_ok_d5 & dep_idle;
		end else if (dir_wait) begin
			// done once the move has been seen and is over
			if (motor_busy) begin
				dir_seen <= 1'b1;
			end else if (dir_seen) begin
				exe_done <= 1'b1;
				dir_wait <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/align_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module align_top
	import align_types_pkg::*, motor_pkg::*;
#(
	parameter bit l2r = 1'b1
) (
	input  logic      clk,
	input  logic      resetn,
	input  logic      req_ecf,
	input  logic      req_dep_img,
	input  logic      req_abs,
	input  pixel_t    req_img_dst,
	input  pixel_t    req_img_tol,
	input  speed_t    req_speed,
	input  step_t     req_step,
	input  logic      req_go,
	input  logic      tbl_wr,
	input  tbl_addr_t tbl_addr,
	input  step_t     tbl_data,
	input  logic      edge_valid,
	input  edge_id_e  edge_id,
	input  pixel_t    edge_y,
	input  logic      frame_end,
	input  logic      dep_busy,
	output logic      exe_done,
	output logic      step_pulse,
	output logic      step_dir,
	output logic      motor_busy,
	output step_t     motor_pos
);

	// frame record
	logic   img_pulse;
	logic   outer_valid;
	logic   inner_valid;
	pixel_t lo_y;
	pixel_t ro_y;
	pixel_t li_y;
	pixel_t ri_y;

	// table read
	tbl_addr_t tbl_rd_addr;
	step_t     tbl_rd_data;

	// move command
	logic   mv_start;
	speed_t mv_speed;
	step_t  mv_step;
	logic   mv_abs;

	edge_sampler sampler_i (
		.clk         (clk),
		.resetn      (resetn),
		.edge_valid  (edge_valid),
		.edge_id     (edge_id),
		.edge_y      (edge_y),
		.frame_end   (frame_end),
		.img_pulse   (img_pulse),
		.lo_y        (lo_y),
		.ro_y        (ro_y),
		.li_y        (li_y),
		.ri_y        (ri_y),
		.outer_valid (outer_valid),
		.inner_valid (inner_valid)
	);

	align_ctl #(
		.l2r (l2r)
	) ctl_i (
		.clk         (clk),
		.resetn      (resetn),
		.req_go      (req_go),
		.req_ecf     (req_ecf),
		.req_dep_img (req_dep_img),
		.req_abs     (req_abs),
		.req_img_dst (req_img_dst),
		.req_img_tol (req_img_tol),
		.req_speed   (req_speed),
		.req_step    (req_step),
		.img_pulse   (img_pulse),
		.outer_valid (outer_valid),
		.inner_valid (inner_valid),
		.lo_y        (lo_y),
		.ro_y        (ro_y),
		.li_y        (li_y),
		.ri_y        (ri_y),
		.motor_busy  (motor_busy),
		.dep_busy    (dep_busy),
		.tbl_rd_addr (tbl_rd_addr),
		.tbl_rd_data (tbl_rd_data),
		.mv_start    (mv_start),
		.mv_speed    (mv_speed),
		.mv_step     (mv_step),
		.mv_abs      (mv_abs),
		.exe_done    (exe_done)
	);

	step_table table_i (
		.clk         (clk),
		.resetn      (resetn),
		.tbl_wr      (tbl_wr),
		.tbl_addr    (tbl_addr),
		.tbl_rd_addr (tbl_rd_addr),
		.tbl_data    (tbl_data),
		.tbl_rd_data (tbl_rd_data)
	);

	stepper_drive drive_i (
		.clk        (clk),
		.resetn     (resetn),
		.mv_start   (mv_start),
		.mv_abs     (mv_abs),
		.mv_speed   (mv_speed),
		.mv_step    (mv_step),
		.step_pulse (step_pulse),
		.step_dir   (step_dir),
		.motor_busy (motor_busy),
		.motor_pos  (motor_pos)
	);

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int half_period = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	// 8 ns period
	always #half_period clk = ~clk;

endmodule

`default_nettype wire

// ==== dv/align_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module align_sva (
	input logic clk,
	input logic resetn,
	input logic mv_start,
	input logic img_pulse,
	input logic motor_busy,
	input logic step_pulse
);

	// controller must wait for an idle drive
	a_start_idle: assert property (@(posedge clk) disable iff (!resetn)
		mv_start |-> !motor_busy)
		else $error("move start while the drive is busy");

	a_start_strobe: assert property (@(posedge clk) disable iff (!resetn)
		mv_start |=> !mv_start)
		else $error("mv_start longer than one cycle");

	a_img_strobe: assert property (@(posedge clk) disable iff (!resetn)
		img_pulse |=> !img_pulse)
		else $error("img_pulse longer than one cycle");

	a_step_busy: assert property (@(posedge clk) disable iff (!resetn)
		step_pulse |-> motor_busy)
		else $error("step pulse while the drive is idle");

endmodule

bind align_top align_sva sva_i (
	.clk        (clk),
	.resetn     (resetn),
	.mv_start   (mv_start),
	.img_pulse  (img_pulse),
	.motor_busy (motor_busy),
	.step_pulse (step_pulse)
);

`default_nettype wire

// ==== dv/align_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module align_tb
	import align_types_pkg::*, motor_pkg::*;
();

	// table load, direct moves, and worst case per frame with a full move
	localparam int table_cycles = 300;
	localparam int direct_cycles = 111 + 20 + 66 + 65 + 5 * 30;
	localparam int max_frames = 80;
	localparam int frame_cycles = 20 + 129 * 2;
	localparam int watchdog_cycles = table_cycles + direct_cycles
		+ max_frames * frame_cycles + 1000;

	logic      clk;
	logic      resetn;
	logic      req_ecf;
	logic      req_dep_img;
	logic      req_abs;
	logic      req_go;
	pixel_t    req_img_dst;
	pixel_t    req_img_tol;
	speed_t    req_speed;
	step_t     req_step;
	logic      tbl_wr;
	tbl_addr_t tbl_addr;
	step_t     tbl_data;
	logic      edge_valid;
	edge_id_e  edge_id;
	pixel_t    edge_y;
	logic      frame_end;
	logic      dep_busy;
	logic      exe_done;
	logic      step_pulse;
	logic      step_dir;
	logic      motor_busy;
	step_t     motor_pos;

	// reference model state
	int seed;
	int err_cnt;
	int m_pos;
	bit m_done;
	int tbl_model [0:255];
	bit self_cur;
	bit self_prev;
	bit dep_cur;
	bit dep_prev;
	bit m_self_idle;
	bit m_dep_idle;
	bit fe_prev;

	tb_clk_gen clk_gen_i (.clk(clk));

	align_top #(.l2r(1'b1)) dut_i (
		.clk(clk), .resetn(resetn),
		.req_ecf(req_ecf), .req_dep_img(req_dep_img), .req_abs(req_abs),
		.req_img_dst(req_img_dst), .req_img_tol(req_img_tol),
		.req_speed(req_speed), .req_step(req_step), .req_go(req_go),
		.tbl_wr(tbl_wr), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
		.edge_valid(edge_valid), .edge_id(edge_id), .edge_y(edge_y),
		.frame_end(frame_end), .dep_busy(dep_busy), .exe_done(exe_done),
		.step_pulse(step_pulse), .step_dir(step_dir),
		.motor_busy(motor_busy), .motor_pos(motor_pos)
	);

	// busy over the current and the last frame interval
	// the cycle after frame_end still closes the interval
	always @(negedge clk) begin
		if (!resetn) begin
			self_cur    = 0;
			self_prev   = 0;
			dep_cur     = 0;
			dep_prev    = 0;
			m_self_idle = 0;
			m_dep_idle  = 0;
			fe_prev     = 0;
		end else begin
			if (fe_prev) begin
				m_self_idle = !(self_prev || self_cur || motor_busy);
				m_dep_idle  = !(dep_prev || dep_cur || dep_busy);
				self_prev = self_cur || motor_busy;
				dep_prev  = dep_cur || dep_busy;
				self_cur = 0;
				dep_cur  = 0;
			end else begin
				if (motor_busy)
					self_cur = 1;
				if (dep_busy)
					dep_cur = 1;
			end
			fe_prev = frame_end;
		end
	end

	task automatic check_value(input int actual, input int expected, input string msg);
		if (actual !== expected) begin
			err_cnt++;
			$display("MISMATCH at %0t ns: %s, got %0d, expected %0d",
				$time, msg, actual, expected);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// entry a holds half of a, rounded up, so corrections converge
	task automatic load_table;
		for (int a = 0; a < 256; a++) begin
			@(posedge clk);
			tbl_wr   <= 1'b1;
			tbl_addr <= tbl_addr_t'(a);
			tbl_data <= step_t'((a + 1) >> 1);
			tbl_model[a] = (a + 1) >> 1;
		end
		@(posedge clk);
		tbl_wr <= 1'b0;
	endtask

	task automatic run_direct(input int step, input int speed, input bit absolute);
		int target;
		int pulses;
		int low_cycles;
		bit dir;
		target = absolute ? step : m_pos + step;
		dir = target > m_pos;
		pulses = 0;
		low_cycles = 0;
		@(posedge clk);
		req_dep_img <= 1'b0;
		req_step    <= step_t'(step);
		req_speed   <= speed_t'(speed);
		req_abs     <= absolute;
		req_go      <= 1'b1;
		@(posedge clk);
		req_go <= 1'b0;
		@(negedge clk);
		check_value(int'(exe_done), 0, "exe_done not cleared by req_go");
		while (!exe_done) begin
			// idle cycles since the drive last reported busy
			if (motor_busy)
				low_cycles = 0;
			else
				low_cycles++;
			if (step_pulse) begin
				pulses++;
				check_value(int'(step_dir), int'(dir), "step_dir during direct move");
			end
			@(negedge clk);
		end
		check_value(int'(motor_busy), 0, "exe_done set while the drive is busy");
		check_value(low_cycles, 1, "exe_done not set the cycle after the drive went idle");
		check_value(pulses, (target > m_pos) ? target - m_pos : m_pos - target,
			"step pulse count of direct move");
		check_value(int'(motor_pos), target, "position after direct move");
		m_pos = target;
		m_done = 1;
	endtask

	task automatic report_edge(input edge_id_e id, input int y);
		@(posedge clk);
		edge_valid <= 1'b1;
		edge_id    <= id;
		edge_y     <= pixel_t'(y);
	endtask

	// one frame and its decision 8 cycles after frame_end
	task automatic run_frame(input int lo, input int ro, input int li, input int ri,
			input bit has_outer, input bit has_inner);
		int od;
		int id;
		int pos;
		int err;
		int mag;
		int addr;
		bit in_tol;
		bit needback;
		bit used;
		bit move;
		if (has_outer) begin
			// first lo report is overwritten by the second
			report_edge(edge_lo, lo + 7);
			report_edge(edge_ro, ro);
		end
		report_edge(edge_lo, lo);
		if (has_inner) begin
			report_edge(edge_ri, ri);
			report_edge(edge_li, li);
		end
		@(posedge clk);
		edge_valid <= 1'b0;
		frame_end  <= 1'b1;
		@(posedge clk);
		frame_end <= 1'b0;
		repeat (7) @(posedge clk);
		@(negedge clk);
		od = lo - ro;
		id = li - ri;
		pos = (req_ecf && has_inner) ? id - ((od - id) >>> 2) : od;
		err = (pos > 0) ? pos - int'(req_img_dst) : pos + int'(req_img_dst);
		needback = err <= 0;
		mag = (err < 0) ? -err : err;
		in_tol = mag < int'(req_img_tol);
		addr = (mag > 255) ? 255 : mag;
		used = req_dep_img && has_outer;
		move = used && m_self_idle && !in_tol;
		if (used)
			m_done = in_tol && m_dep_idle;
		check_value(int'(exe_done), int'(m_done), "exe_done after frame");
		@(negedge clk);
		check_value(int'(motor_busy), int'(move), "move start after frame");
		if (move) begin
			m_pos += needback ? -tbl_model[addr] : tbl_model[addr];
			while (motor_busy)
				@(negedge clk);
			check_value(int'(motor_pos), m_pos, "position after image move");
		end
	endtask

	// frames without the right edge age out the busy history
	task automatic settle_axis;
		repeat (2) run_frame(100, 0, 0, 0, 1'b0, 1'b0);
	endtask

	task automatic direct_moves;
		run_direct(37, 3, 1'b0);
		run_direct(-20, 0, 1'b0);
		run_direct(50, 2, 1'b1);
		run_direct(-15, 1, 1'b1);
		run_direct(0, 1, 1'b0);
	endtask

	task automatic tolerance_frames;
		@(posedge clk);
		req_dep_img <= 1'b1;
		req_ecf     <= 1'b0;
		req_img_dst <= 12'sd10;
		req_img_tol <= 12'sd3;
		req_speed   <= 16'd2;
		req_go      <= 1'b1;
		@(posedge clk);
		req_go <= 1'b0;
		m_done = 0;
		settle_axis();
		run_frame(300, 289, 0, 0, 1'b1, 1'b0);
		check_value(int'(exe_done), 1, "in tolerance with both axes idle");
		@(posedge clk);
		dep_busy <= 1'b1;
		repeat (3) @(posedge clk);
		dep_busy <= 1'b0;
		run_frame(300, 289, 0, 0, 1'b1, 1'b0);
		check_value(int'(exe_done), 0, "in tolerance with dependent axis busy");
		run_frame(300, 290, 0, 0, 1'b1, 1'b0);
		run_frame(300, 291, 0, 0, 1'b1, 1'b0);
		check_value(int'(exe_done), 1, "dependent axis idle again");
	endtask

	// camera sees the outer difference shrink as the axis advances
	task automatic correction_loop(input bit reverse);
		int pos0;
		int c;
		int lo;
		int od;
		pos0 = m_pos;
		c = 60 + ($random(seed) & 63);
		// negative start error needs moves toward lower positions
		if (reverse)
			c = -c;
		for (int n = 0; n < 30; n++) begin
			od = c - (m_pos - pos0);
			lo = 200 + ($random(seed) & 127);
			run_frame(lo, lo - od, 0, 0, 1'b1, 1'b0);
			if (exe_done)
				break;
		end
		check_value(int'(exe_done), 1, "error not driven into tolerance");
		if (reverse)
			check_value(int'(motor_pos < step_t'(pos0)), 1, "correction did not move back");
		else
			check_value(int'(motor_pos > step_t'(pos0)), 1, "correction did not move forward");
	endtask

	task automatic eccentricity_frames;
		int lo;
		int li;
		@(posedge clk);
		req_ecf <= 1'b1;
		settle_axis();
		lo = 300 + ($random(seed) & 63);
		li = lo - 10;
		run_frame(lo, lo - 100, li, li - 80 - ($random(seed) & 15), 1'b1, 1'b1);
		// axis just moved, so this one must not start a move
		run_frame(lo, lo - 100, li, li - 85, 1'b1, 1'b1);
		settle_axis();
		run_frame(lo, lo - 90, 0, 0, 1'b1, 1'b0);
		// idle axis, so only the missing right edge holds the move back
		settle_axis();
		run_frame(lo, lo - 90, li, li - 80, 1'b0, 1'b1);
		@(posedge clk);
		req_ecf <= 1'b0;
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout, tests did not finish within %0d cycles", watchdog_cycles);
		$display("Something failed");
		$fatal(1);
	end

	initial begin
		seed        = 11288;
		err_cnt     = 0;
		m_pos       = 0;
		m_done      = 0;
		resetn      = 1'b0;
		req_ecf     = 1'b0;
		req_dep_img = 1'b0;
		req_abs     = 1'b0;
		req_go      = 1'b0;
		req_img_dst = '0;
		req_img_tol = '0;
		req_speed   = 16'd1;
		req_step    = '0;
		tbl_wr      = 1'b0;
		tbl_addr    = '0;
		tbl_data    = '0;
		edge_valid  = 1'b0;
		edge_id     = edge_lo;
		edge_y      = '0;
		frame_end   = 1'b0;
		dep_busy    = 1'b0;
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		load_table();
		direct_moves();
		tolerance_frames();
		correction_loop(1'b0);
		correction_loop(1'b1);
		eccentricity_frames();
		@(posedge clk);
		if (err_cnt == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/align_types_pkg.sv
rtl/motor_pkg.sv
rtl/edge_sampler.sv
rtl/step_table.sv
rtl/stepper_drive.sv
rtl/align_ctl.sv
rtl/align_top.sv
dv/tb_clk_gen.sv
dv/align_sva.sv
dv/align_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module align_tb -o align_sim

# the exit status of tee hides the simulator status, so the log decides
./obj_dir/align_sim 2>&1 | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
if ! grep -q "Everything OK" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
